// File: ring_consts.svh
`ifndef RING_CONSTS_SVH
`define RING_CONSTS_SVH

// Frame fields
`define RING_ADDR_WIDTH 8
`define RING_DATA_WIDTH 32

// Host bus widths
`define RING_APB_ADDR_WIDTH 5
`define RING_APB_DATA_WIDTH 32

`define MSG_FIFO_DEPTH 4
`define RING_NODE_ADDR 8'hEF
`define RING_NODE_MASK 8'hFF

`endif

// File: ring_frame_pkg.sv
`include "ring_consts.svh"

package ring_frame_pkg;

	// One message as it travels on the ring, address first
	typedef struct packed
	{
		logic [`RING_ADDR_WIDTH-1:0] addr;
		logic [`RING_DATA_WIDTH-1:0] data;
	} ring_msg_t;

	// Serial state of the node
	typedef enum logic [2:0]
	{
		st_idle,
		st_tx_start,
		st_tx_addr,
		st_tx_data,
		st_tx_end,
		st_rx_addr,
		st_rx_data,
		st_rx_end
	} node_state_t;

endpackage

// File: host_reg_pkg.sv
package host_reg_pkg;

	// APB byte offsets
	typedef enum logic [4:0]
	{
		off_tx_addr = 5'h00,
		off_tx_data = 5'h04,
		off_rx_addr = 5'h08,
		off_rx_data = 5'h0C,
		off_status  = 5'h10
	} reg_offset_t;

	// STATUS word, bit 0 is rx_avail
	typedef struct packed
	{
		logic [28:0] reserved;
		logic        rx_overflow;
		logic        tx_full;
		logic        rx_avail;
	} status_t;

endpackage

// File: msg_fifo.sv
`include "ring_consts.svh"

module msg_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = `MSG_FIFO_DEPTH
) (
	input  logic     CLKIN,
	input  logic     RESETn,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

	payload_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != FULL_COUNT);
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];
	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

	always_ff @(posedge CLKIN)
	begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

endmodule

// File: host_regs.sv
`include "ring_consts.svh"

module host_regs
	import ring_frame_pkg::*;
	import host_reg_pkg::*;
(
	input  logic                            CLKIN,
	input  logic                            RESETn,
	input  logic [`RING_APB_ADDR_WIDTH-1:0] paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [`RING_APB_DATA_WIDTH-1:0] pwdata,
	output logic [`RING_APB_DATA_WIDTH-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic                            tx_valid,
	output ring_msg_t                       tx_data,
	input  logic                            tx_ready,
	input  logic                            rx_valid,
	input  ring_msg_t                       rx_data,
	output logic                            rx_ready,
	input  logic                            rx_overflow_pulse
);

	reg_offset_t offset;
	status_t status;
	status_t wr_status;
	logic access;
	logic wr_access;
	logic rd_access;
	logic rx_read;
	logic overflow_clr;
	logic rx_overflow;
	logic [`RING_ADDR_WIDTH-1:0] tx_addr_q;

	assign offset = reg_offset_t'(paddr);
	assign access = psel && penable;
	assign wr_access = access && pwrite;
	assign rd_access = access && !pwrite;

	// A push happens in the access phase itself
	assign tx_valid = wr_access && (offset == off_tx_data);
	assign tx_data.addr = tx_addr_q;
	assign tx_data.data = pwdata;

	// Only a push into a full queue stalls the bus
	assign pready = !(tx_valid && !tx_ready);

	assign rx_read = rd_access && ((offset == off_rx_addr) || (offset == off_rx_data));
	assign rx_ready = rd_access && (offset == off_rx_data);
	assign pslverr = rx_read && !rx_valid;

	assign wr_status = status_t'(pwdata);
	assign overflow_clr = wr_access && (offset == off_status) && wr_status.rx_overflow;

	always_comb
	begin
		status = '0;
		status.rx_avail = rx_valid;
		status.tx_full = !tx_ready;
		status.rx_overflow = rx_overflow;
	end

	always_comb
	begin
		prdata = '0;
		if (rd_access)
		begin
			case (offset)
				off_rx_addr:
				begin
					if (rx_valid)
						prdata[`RING_ADDR_WIDTH-1:0] = rx_data.addr;
				end
				off_rx_data:
				begin
					if (rx_valid)
						prdata[`RING_DATA_WIDTH-1:0] = rx_data.data;
				end
				off_status:
					prdata = status;
				default:
					prdata = '0;
			endcase
		end
	end

	always_ff @(posedge CLKIN)
	begin
		if (wr_access && (offset == off_tx_addr))
			tx_addr_q <= pwdata[`RING_ADDR_WIDTH-1:0];
	end

	// Sticky until the host writes 1 to bit 2, a new drop wins
	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
			rx_overflow <= 1'b0;
		else if (rx_overflow_pulse)
			rx_overflow <= 1'b1;
		else if (overflow_clr)
			rx_overflow <= 1'b0;
	end

endmodule

// File: ring_node.sv
`include "ring_consts.svh"

module ring_node
	import ring_frame_pkg::*;
#(
	parameter logic [`RING_ADDR_WIDTH-1:0] NODE_ADDR = `RING_NODE_ADDR,
	parameter logic [`RING_ADDR_WIDTH-1:0] NODE_MASK = `RING_NODE_MASK
) (
	input  logic      CLKIN,
	input  logic      RESETn,
	input  logic      din,
	output logic      dout,
	input  logic      tx_valid,
	input  ring_msg_t tx_data,
	output logic      tx_ready,
	output logic      rx_valid,
	output ring_msg_t rx_data,
	input  logic      rx_ready,
	output logic      rx_overflow_pulse
);

	localparam int MSG_W = $bits(ring_msg_t);
	localparam int CNT_W = $clog2(`RING_DATA_WIDTH);
	localparam logic [CNT_W-1:0] ADDR_LAST = CNT_W'(`RING_ADDR_WIDTH - 1);
	localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(`RING_DATA_WIDTH - 1);

	node_state_t state;
	node_state_t state_next;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_next;
	logic [MSG_W-1:0] sr;
	logic [MSG_W-1:0] sr_next;
	logic dout_next;
	logic din_q;
	logic rx_valid_next;
	logic addr_match;

	// Line must have been idle one cycle before we start a frame
	assign tx_ready = (state == st_idle) && din_q;

	assign addr_match = (((sr[MSG_W-1 -: `RING_ADDR_WIDTH] ^ NODE_ADDR) & NODE_MASK) == '0);

	// Ring cannot stall, so a refused push is a lost frame
	assign rx_overflow_pulse = rx_valid && !rx_ready;

	always_comb
	begin
		state_next = state;
		cnt_next = cnt;
		sr_next = sr;
		dout_next = din;
		rx_valid_next = 1'b0;
		case (state)
			st_idle:
			begin
				if (tx_valid && tx_ready)
				begin
					sr_next = tx_data;
					dout_next = 1'b0;
					state_next = st_tx_start;
				end
				else if (!din)
				begin
					cnt_next = ADDR_LAST;
					state_next = st_rx_addr;
				end
			end
			st_tx_start:
			begin
				dout_next = sr[MSG_W-1];
				sr_next = {sr[MSG_W-2:0], 1'b0};
				cnt_next = ADDR_LAST;
				state_next = st_tx_addr;
			end
			st_tx_addr:
			begin
				dout_next = sr[MSG_W-1];
				sr_next = {sr[MSG_W-2:0], 1'b0};
				cnt_next = (cnt == '0) ? DATA_LAST : cnt - 1'b1;
				if (cnt == '0)
					state_next = st_tx_data;
			end
			st_tx_data:
			begin
				dout_next = sr[MSG_W-1];
				sr_next = {sr[MSG_W-2:0], 1'b0};
				cnt_next = cnt - 1'b1;
				if (cnt == '0)
				begin
					// End bit
					dout_next = 1'b1;
					state_next = st_tx_end;
				end
			end
			st_tx_end:
			begin
				// Forced idle before the line is handed back to din
				dout_next = 1'b1;
				state_next = st_idle;
			end
			st_rx_addr:
			begin
				sr_next = {sr[MSG_W-2:0], din};
				cnt_next = (cnt == '0) ? DATA_LAST : cnt - 1'b1;
				if (cnt == '0)
					state_next = st_rx_data;
			end
			st_rx_data:
			begin
				sr_next = {sr[MSG_W-2:0], din};
				cnt_next = cnt - 1'b1;
				if (cnt == '0)
					state_next = st_rx_end;
			end
			st_rx_end:
			begin
				rx_valid_next = din && addr_match;
				state_next = st_idle;
			end
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge CLKIN or negedge RESETn)
	begin
		if (!RESETn)
		begin
			state <= st_idle;
			cnt <= '0;
			dout <= 1'b1;
			din_q <= 1'b0;
			rx_valid <= 1'b0;
		end
		else
		begin
			state <= state_next;
			cnt <= cnt_next;
			dout <= dout_next;
			din_q <= din;
			rx_valid <= rx_valid_next;
		end
	end

	always_ff @(posedge CLKIN)
	begin
		sr <= sr_next;
		if (state == st_rx_end)
			rx_data <= ring_msg_t'(sr);
	end

endmodule

// File: ring_port.sv
`include "ring_consts.svh"

module ring_port
	import ring_frame_pkg::*;
(
	input  logic                            CLKIN,
	input  logic                            RESETn,
	input  logic [`RING_APB_ADDR_WIDTH-1:0] paddr,
	input  logic                            psel,
	input  logic                            penable,
	input  logic                            pwrite,
	input  logic [`RING_APB_DATA_WIDTH-1:0] pwdata,
	output logic [`RING_APB_DATA_WIDTH-1:0] prdata,
	output logic                            pready,
	output logic                            pslverr,
	input  logic                            din,
	output logic                            dout
);

	logic tx_in_valid;
	logic tx_in_ready;
	ring_msg_t tx_in_data;
	logic tx_out_valid;
	logic tx_out_ready;
	ring_msg_t tx_out_data;
	logic rx_in_valid;
	logic rx_in_ready;
	ring_msg_t rx_in_data;
	logic rx_out_valid;
	logic rx_out_ready;
	ring_msg_t rx_out_data;
	logic rx_overflow_pulse;

	host_regs host_regs_i (
		.CLKIN(CLKIN), .RESETn(RESETn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.tx_valid(tx_in_valid), .tx_data(tx_in_data), .tx_ready(tx_in_ready),
		.rx_valid(rx_out_valid), .rx_data(rx_out_data), .rx_ready(rx_out_ready),
		.rx_overflow_pulse(rx_overflow_pulse)
	);

	msg_fifo #(.payload_t(ring_msg_t), .DEPTH(`MSG_FIFO_DEPTH)) tx_fifo_i (
		.CLKIN(CLKIN), .RESETn(RESETn),
		.in_valid(tx_in_valid), .in_data(tx_in_data), .in_ready(tx_in_ready),
		.out_valid(tx_out_valid), .out_data(tx_out_data), .out_ready(tx_out_ready)
	);

	msg_fifo #(.payload_t(ring_msg_t), .DEPTH(`MSG_FIFO_DEPTH)) rx_fifo_i (
		.CLKIN(CLKIN), .RESETn(RESETn),
		.in_valid(rx_in_valid), .in_data(rx_in_data), .in_ready(rx_in_ready),
		.out_valid(rx_out_valid), .out_data(rx_out_data), .out_ready(rx_out_ready)
	);

	ring_node #(.NODE_ADDR(`RING_NODE_ADDR), .NODE_MASK(`RING_NODE_MASK)) ring_node_i (
		.CLKIN(CLKIN), .RESETn(RESETn), .din(din), .dout(dout),
		.tx_valid(tx_out_valid), .tx_data(tx_out_data), .tx_ready(tx_out_ready),
		.rx_valid(rx_in_valid), .rx_data(rx_in_data), .rx_ready(rx_in_ready),
		.rx_overflow_pulse(rx_overflow_pulse)
	);

endmodule

// File: ring_port_tb.sv
`include "ring_consts.svh"

module ring_port_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int READY_LIMIT = 200;
	localparam int FRAME_LIMIT = 400;

	logic CLKIN;
	logic RESETn;
	logic [`RING_APB_ADDR_WIDTH-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`RING_APB_DATA_WIDTH-1:0] pwdata;
	logic [`RING_APB_DATA_WIDTH-1:0] prdata;
	logic pready;
	logic pslverr;
	logic din;
	logic dout;

	logic [31:0] rng_state;
	// Decoded dout frames as {addr, data, end bit}
	logic [40:0] frames[$];

	ring_port dut_i (
		.CLKIN(CLKIN), .RESETn(RESETn),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.din(din), .dout(dout)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic compare_val(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
			abort_run($sformatf("[ERROR] time %0d ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual));
	endtask

	task automatic require_complete_line(input bit complete);
		if (!complete)
			abort_run("A line in the stimulus file has too few fields");
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	initial
	begin
		CLKIN = 1'b0;
		forever #2 CLKIN = ~CLKIN;
	end

	task automatic apb_xfer(input logic [4:0] addr, input logic write,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		@(posedge CLKIN);
		paddr <= addr;
		pwrite <= write;
		pwdata <= wdata;
		psel <= 1'b1;
		penable <= 1'b0;
		@(posedge CLKIN);
		penable <= 1'b1;
		waited = 0;
		@(negedge CLKIN);
		// TX_DATA into a full queue holds the access phase
		while (pready !== 1'b1)
		begin
			waited++;
			if (waited > READY_LIMIT)
				abort_run("Timeout: pready stayed low in an APB access phase");
			@(negedge CLKIN);
		end
		// Every other transfer ends in its first access cycle
		if (!(write && addr == 5'h04))
			compare_val("pready wait cycles", 0, waited);
		rdata = prdata;
		err = pslverr;
		@(posedge CLKIN);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic send_frame(input logic [7:0] addr, input logic [31:0] data,
		input logic end_bit);
		logic [40:0] bits;
		int gap;
		int i;
		rng_state = xorshift32(rng_state);
		gap = 1 + int'(rng_state % 8);
		repeat (gap)
		begin
			@(posedge CLKIN);
			din <= 1'b1;
		end
		bits = {1'b0, addr, data};
		for (i = 40; i >= 0; i--)
		begin
			@(posedge CLKIN);
			din <= bits[i];
		end
		@(posedge CLKIN);
		din <= end_bit;
		@(posedge CLKIN);
		din <= 1'b1;
	endtask

	task automatic expect_frame(input logic [7:0] addr, input logic [31:0] data,
		input logic end_bit);
		logic [40:0] got;
		int waited;
		waited = 0;
		while (frames.size() == 0)
		begin
			@(posedge CLKIN);
			waited++;
			if (waited > FRAME_LIMIT)
				abort_run("Timeout: no frame appeared on dout");
		end
		got = frames.pop_front();
		compare_val("frame addr", addr, got[40:33]);
		compare_val("frame data", data, got[32:1]);
		compare_val("frame end bit", end_bit, got[0]);
	endtask

	// Start bit, then 40 payload bits and the end bit
	initial
	begin : dout_monitor
		logic [40:0] bits;
		forever
		begin
			@(negedge CLKIN);
			if (RESETn === 1'b1 && dout === 1'b0)
			begin
				repeat (41)
				begin
					@(negedge CLKIN);
					bits = {bits[39:0], dout};
				end
				frames.push_back(bits);
			end
		end
	end

	initial
	begin : run
		int fd;
		int code;
		int cycles;
		byte cmd;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] rdata;
		logic err;
		reg [8*256-1:0] skip;
		RESETn <= 1'b0;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		din <= 1'b1;
		rng_state = 32'd4;
		fd = $fopen("ring_port_stimulus.txt", "r");
		if (fd == 0)
			abort_run("Could not open ring_port_stimulus.txt");
		repeat (2) @(posedge CLKIN);
		RESETn <= 1'b1;
		code = $fscanf(fd, " %c", cmd);
		while (code == 1)
		begin
			case (cmd)
				"#":
					code = $fgets(skip, fd);
				"W":
				begin
					require_complete_line($fscanf(fd, "%h %h", a, b) == 2);
					apb_xfer(a[4:0], 1'b1, b, rdata, err);
					compare_val("write pslverr", 0, err);
				end
				"R":
				begin
					require_complete_line($fscanf(fd, "%h %h %h", a, b, c) == 3);
					apb_xfer(a[4:0], 1'b0, '0, rdata, err);
					compare_val($sformatf("prdata at 0x%02h", a[4:0]), b, rdata);
					compare_val($sformatf("pslverr at 0x%02h", a[4:0]), c[0], err);
				end
				"F":
				begin
					require_complete_line($fscanf(fd, "%h %h %h", a, b, c) == 3);
					send_frame(a[7:0], b, c[0]);
				end
				"E":
				begin
					require_complete_line($fscanf(fd, "%h %h %h", a, b, c) == 3);
					expect_frame(a[7:0], b, c[0]);
				end
				"G":
				begin
					require_complete_line($fscanf(fd, "%d", cycles) == 1);
					repeat (cycles) @(posedge CLKIN);
				end
				default:
					abort_run($sformatf("Unknown command '%c' in the stimulus file", cmd));
			endcase
			code = $fscanf(fd, " %c", cmd);
		end
		$fclose(fd);
		if (frames.size() != 0)
			abort_run($sformatf("%0d frames on dout were never checked", frames.size()));
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

// File: ring_port.f
+incdir+.
ring_frame_pkg.sv
host_reg_pkg.sv
msg_fifo.sv
host_regs.sv
ring_node.sv
ring_port.sv
ring_port_tb.sv

// File: ring_port_stimulus.txt
# W addr wdata | R addr exp_rdata exp_pslverr | G idle_cycles (decimal, the rest hex)
# F addr data end_bit drives din, E addr data end_bit expects the next frame on dout
W 00 A5
W 04 12345678
E A5 12345678 1
G 4
F EF CAFEF00D 1
E EF CAFEF00D 1
R 10 1 0
R 08 EF 0
R 0C CAFEF00D 0
R 10 0 0
F 12 0000BEEF 1
E 12 0000BEEF 1
R 10 0 0
R 0C 0 1
F EF 11111111 1
E EF 11111111 1
F EF 22222222 1
E EF 22222222 1
F EF 33333333 1
E EF 33333333 1
F EF 44444444 1
E EF 44444444 1
F EF 55555555 1
E EF 55555555 1
R 10 5 0
R 0C 11111111 0
R 0C 22222222 0
R 0C 33333333 0
R 0C 44444444 0
R 0C 0 1
R 10 4 0
W 10 4
R 10 0 0
W 00 3C
W 04 A0000001
W 04 A0000002
W 04 A0000003
W 04 A0000004
W 04 A0000005
W 04 A0000006
E 3C A0000001 1
E 3C A0000002 1
E 3C A0000003 1
E 3C A0000004 1
E 3C A0000005 1
E 3C A0000006 1
G 6
F EF 0BADF00D 0
E EF 0BADF00D 0
R 10 0 0
